/* z3_pkg.sv */
// shared widths, state and opcode types, bus structs and autoconfig identity data for the slave
package z3_pkg;

	// bus widths
	localparam int ADDR_W = 30;
	localparam int DATA_W = 32;
	localparam int BE_W = 4;

	// autoconfig space is FF00xxxx
	localparam logic [15:0] CFG_SPACE_HI = 16'hFF00;
	// card occupies one 64 MB slot, compare A31..A26 only
	localparam int CARD_MATCH_BITS = 6;
	// register index is A8..A2
	localparam logic [6:0] CFG_BASE_IDX = 7'h11;
	localparam logic [6:0] CFG_SHUTUP_IDX = 7'h13;

	// identity nibbles in true polarity
	// 0..1 board type, 2..3 product, 4..5 flags, 6..7 reserved
	// 8..11 manufacturer, 12..15 serial
	localparam logic [3:0] CFG_ROM [16] = '{
		4'hA, 4'h0, 4'h0, 4'h5,
		4'h3, 4'h0, 4'h0, 4'h0,
		4'h0, 4'h7, 4'hD, 4'hB,
		4'h0, 4'h0, 4'h0, 4'h1
	};

	typedef enum logic [2:0] {
		ZS_IDLE,
		ZS_MATCH,
		ZS_DATA,
		ZS_WAIT_MEM,
		ZS_DTACK
	} z3_state_e;

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

	// bus cycle as seen by the card, strobes still active low
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic read;
		logic [BE_W-1:0] ds_n;
		logic [1:0] fc;
	} z3_cycle_t;

	typedef struct packed {
		logic card_hit;
		logic cfg_hit;
		logic [6:0] cfg_reg;
	} z3_hit_t;

	// request to the local memory, byte enables active high
	typedef struct packed {
		mem_op_e op;
		logic [23:0] word_addr;
		logic [BE_W-1:0] be;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

endpackage

/* z3_bus_decode.sv */
// resamples the bus strobes, latches the cycle address and decodes card and autoconfig hits
module z3_bus_decode (
	input  logic clk,
	input  logic rst_n_i,
	input  logic fcs_n_i,
	input  logic doe_i,
	input  logic read_i,
	input  logic [z3_pkg::BE_W-1:0] ds_n_i,
	input  logic [1:0] fc_i,
	input  logic [z3_pkg::ADDR_W-1:0] addr_i,
	input  logic [5:0] base_hi_i,
	input  logic configured_i,
	input  logic shutup_i,
	input  logic cfg_active_i,
	output z3_pkg::z3_cycle_t cycle_o,
	output z3_pkg::z3_hit_t hit_o,
	output logic fcs_r_o,
	output logic doe_r_o,
	output logic select_o
);
	import z3_pkg::*;

	logic fcs_r;
	logic fcs_prev_r;
	logic doe_r;
	logic read_r;
	logic [BE_W-1:0] ds_n_r;
	logic [1:0] fc_r;
	logic [ADDR_W-1:0] addr_r;
	logic [ADDR_W-1:0] addr_q;
	logic fcs_fall;
	logic space_ok;
	logic cfg_match;
	logic card_match;
	z3_hit_t hit_r;
	logic select_r;

	// sampled strobe went high to low
	assign fcs_fall = fcs_prev_r & ~fcs_r;

	// only data and program space (codes 1 and 2)
	assign space_ok = fc_r[0] ^ fc_r[1];
	// addr_q bit 0 is A2
	assign cfg_match = (addr_q[ADDR_W-1 -: 16] == CFG_SPACE_HI) & cfg_active_i;
	assign card_match = configured_i & ~shutup_i &
		(addr_q[ADDR_W-1 -: CARD_MATCH_BITS] == base_hi_i);

	// strobe resampling
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			fcs_r <= 1'b1;
			fcs_prev_r <= 1'b1;
			doe_r <= 1'b0;
			read_r <= 1'b1;
			ds_n_r <= '1;
			fc_r <= 2'b00;
		end else begin
			fcs_r <= fcs_n_i;
			fcs_prev_r <= fcs_r;
			doe_r <= doe_i;
			read_r <= read_i;
			ds_n_r <= ds_n_i;
			fc_r <= fc_i;
		end
	end

	// address taken with the first low strobe sample, held for the cycle
	always_ff @(posedge clk) begin
		addr_r <= addr_i;
		if (fcs_fall)
			addr_q <= addr_r;
	end

	// hits wait one edge for the latched address
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			hit_r <= '0;
			select_r <= 1'b0;
		end else if (fcs_r || fcs_fall) begin
			hit_r <= '0;
			select_r <= 1'b0;
		end else begin
			hit_r.card_hit <= card_match;
			hit_r.cfg_hit <= cfg_match;
			hit_r.cfg_reg <= addr_q[6:0];
			select_r <= (card_match | cfg_match) & space_ok;
		end
	end

	assign cycle_o.addr = addr_q;
	assign cycle_o.read = read_r;
	assign cycle_o.ds_n = ds_n_r;
	assign cycle_o.fc = fc_r;
	assign hit_o = hit_r;
	assign fcs_r_o = fcs_r;
	assign doe_r_o = doe_r;
	assign select_o = select_r;

endmodule

/* z3_autoconfig.sv */
// autoconfig register block with identity ROM, base address and shut-up writes, and config chain
module z3_autoconfig (
	input  logic clk,
	input  logic rst_n_i,
	input  logic cfgin_n_i,
	input  logic [6:0] cfg_reg_i,
	input  logic cfg_write_stb_i,
	input  logic [z3_pkg::DATA_W-1:0] wdata_i,
	output logic [3:0] cfg_nibble_o,
	output logic [5:0] base_hi_o,
	output logic configured_o,
	output logic shutup_o,
	output logic cfg_active_o,
	output logic cfgout_n_o
);
	import z3_pkg::*;

	logic cfgin_n_r;
	logic configured_r;
	logic shutup_r;
	logic [5:0] base_hi_r;
	logic [3:0] rom_nibble;

	// chain input is asynchronous to clk
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			cfgin_n_r <= 1'b1;
		else
			cfgin_n_r <= cfgin_n_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			configured_r <= 1'b0;
			shutup_r <= 1'b0;
			base_hi_r <= '0;
		end else if (cfg_write_stb_i) begin
			// base write carries A31..A26 in the top data bits
			if (cfg_reg_i == CFG_BASE_IDX) begin
				base_hi_r <= wdata_i[DATA_W-1 -: CARD_MATCH_BITS];
				configured_r <= 1'b1;
			end
			// shut-up, board stays off the bus for good
			if (cfg_reg_i == CFG_SHUTUP_IDX)
				shutup_r <= 1'b1;
		end
	end

	assign rom_nibble = CFG_ROM[cfg_reg_i[3:0]];

	// identity read
	always_comb begin
		if (cfg_reg_i > 7'd15)
			cfg_nibble_o = 4'hF;
		else if (cfg_reg_i < 7'd2)
			cfg_nibble_o = rom_nibble;
		else
			// all registers past the type byte read back inverted
			cfg_nibble_o = ~rom_nibble;
	end

	// respond to config space only while it is our turn in the chain
	assign cfg_active_o = ~configured_r & ~shutup_r & ~cfgin_n_r;
	// pass the chain on once done with config
	assign cfgout_n_o = ~(configured_r | shutup_r);

	assign base_hi_o = base_hi_r;
	assign configured_o = configured_r;
	assign shutup_o = shutup_r;

endmodule

/* z3_cycle_seq.sv */
// bus cycle FSM, issues memory requests and drives the slave and data acknowledge outputs
module z3_cycle_seq (
	input  logic clk,
	input  logic rst_n_i,
	input  logic fcs_r_i,
	input  logic doe_r_i,
	input  logic select_i,
	input  z3_pkg::z3_cycle_t cycle_i,
	input  z3_pkg::z3_hit_t hit_i,
	input  logic [z3_pkg::DATA_W-1:0] wdata_i,
	input  logic mem_req_ready_i,
	input  logic mem_rsp_valid_i,
	output z3_pkg::mem_req_t mem_req_o,
	output logic mem_req_valid_o,
	output logic cfg_write_stb_o,
	output logic slave_n_o,
	output logic dtack_n_o
);
	import z3_pkg::*;

	z3_state_e state;
	mem_req_t req_r;
	logic req_valid_r;
	logic cfg_stb_r;
	logic dtack_r;
	logic ds_any;
	logic in_data;
	logic issue_req;
	logic cfg_wr;
	logic req_accept;

	// master has put at least one byte lane up
	assign ds_any = (cycle_i.ds_n != '1);
	assign in_data = (state == ZS_DATA) & ~fcs_r_i;
	// reads go out at once, writes wait for data valid
	assign issue_req = in_data & hit_i.card_hit & (cycle_i.read | ds_any);
	assign cfg_wr = in_data & hit_i.cfg_hit & ~cycle_i.read & ds_any;
	assign req_accept = req_valid_r & mem_req_ready_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state <= ZS_IDLE;
			req_valid_r <= 1'b0;
			cfg_stb_r <= 1'b0;
			dtack_r <= 1'b0;
		end else begin
			cfg_stb_r <= cfg_wr;
			// acknowledge lags the state by one clock
			dtack_r <= (state == ZS_DTACK);
			// valid holds until taken, even past the end of the cycle
			if (req_accept)
				req_valid_r <= 1'b0;
			if (issue_req)
				req_valid_r <= 1'b1;
			if (fcs_r_i) begin
				state <= ZS_IDLE;
			end else begin
				case (state)
					ZS_IDLE: begin
						if (select_i)
							state <= ZS_MATCH;
					end
					ZS_MATCH: begin
						// DOE opens the data phase
						if (doe_r_i)
							state <= ZS_DATA;
					end
					ZS_DATA: begin
						if (issue_req)
							state <= ZS_WAIT_MEM;
						else if (hit_i.cfg_hit && (cycle_i.read || cfg_wr))
							state <= ZS_DTACK;
					end
					ZS_WAIT_MEM: begin
						// reads wait for data, writes only for acceptance
						if (cycle_i.read ? mem_rsp_valid_i : req_accept)
							state <= ZS_DTACK;
					end
					ZS_DTACK: begin
						// held until the master drops fcs
						state <= ZS_DTACK;
					end
					default: begin
						state <= ZS_IDLE;
					end
				endcase
			end
		end
	end

	// request payload, also the latch for config write data
	always_ff @(posedge clk) begin
		if (issue_req || cfg_wr) begin
			req_r.op <= cycle_i.read ? MEM_READ : MEM_WRITE;
			req_r.word_addr <= cycle_i.addr[23:0];
			req_r.be <= ~cycle_i.ds_n;
			req_r.wdata <= cycle_i.read ? '0 : wdata_i;
		end
	end

	assign mem_req_o = req_r;
	assign mem_req_valid_o = req_valid_r;
	assign cfg_write_stb_o = cfg_stb_r;
	assign slave_n_o = ~select_i | fcs_r_i;
	assign dtack_n_o = ~dtack_r | fcs_r_i;

endmodule

/* z3_read_data.sv */
// read data register for memory and config reads, plus the bus data output enable
module z3_read_data (
	input  logic clk,
	input  logic rst_n_i,
	input  z3_pkg::z3_cycle_t cycle_i,
	input  z3_pkg::z3_hit_t hit_i,
	input  logic doe_r_i,
	input  logic slave_n_i,
	input  logic mem_rsp_valid_i,
	input  logic [z3_pkg::DATA_W-1:0] mem_rsp_rdata_i,
	input  logic [3:0] cfg_nibble_i,
	output logic [z3_pkg::DATA_W-1:0] rdata_o,
	output logic data_oe_o
);
	import z3_pkg::*;

	logic [DATA_W-1:0] rdata_r;
	logic oe_r;

	// memory word arrives as a single pulse
	always_ff @(posedge clk) begin
		if (cycle_i.read) begin
			if (hit_i.card_hit && mem_rsp_valid_i)
				rdata_r <= mem_rsp_rdata_i;
			else if (hit_i.cfg_hit)
				// nibble on D31..D28, unused lines read as ones
				rdata_r <= {cfg_nibble_i, {(DATA_W-4){1'b1}}};
		end
	end

	// drive the bus only on our own read data phase
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			oe_r <= 1'b0;
		else
			oe_r <= cycle_i.read & ~slave_n_i & doe_r_i;
	end

	assign rdata_o = rdata_r;
	assign data_oe_o = oe_r;

endmodule

/* z3_slave.sv */
// top level of the Zorro III slave card, connects decode, autoconfig, sequencer and read data
module z3_slave (
	input  logic clk,
	input  logic rst_n_i,
	input  logic fcs_n_i,
	input  logic doe_i,
	input  logic read_i,
	input  logic [z3_pkg::BE_W-1:0] ds_n_i,
	input  logic [1:0] fc_i,
	input  logic [z3_pkg::ADDR_W-1:0] addr_i,
	input  logic [z3_pkg::DATA_W-1:0] wdata_i,
	input  logic cfgin_n_i,
	input  logic mem_req_ready_i,
	input  logic mem_rsp_valid_i,
	input  logic [z3_pkg::DATA_W-1:0] mem_rsp_rdata_i,
	output logic slave_n_o,
	output logic dtack_n_o,
	output logic cfgout_n_o,
	output logic [z3_pkg::DATA_W-1:0] rdata_o,
	output logic data_oe_o,
	output z3_pkg::mem_req_t mem_req_o,
	output logic mem_req_valid_o
);
	import z3_pkg::*;

	z3_cycle_t cycle;
	z3_hit_t hit;
	logic fcs_r;
	logic doe_r;
	logic select;
	logic [5:0] base_hi;
	logic configured;
	logic shutup;
	logic cfg_active;
	logic [3:0] cfg_nibble;
	logic cfg_write_stb;

	z3_bus_decode i_z3_bus_decode (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.fcs_n_i      (fcs_n_i),
		.doe_i        (doe_i),
		.read_i       (read_i),
		.ds_n_i       (ds_n_i),
		.fc_i         (fc_i),
		.addr_i       (addr_i),
		.base_hi_i    (base_hi),
		.configured_i (configured),
		.shutup_i     (shutup),
		.cfg_active_i (cfg_active),
		.cycle_o      (cycle),
		.hit_o        (hit),
		.fcs_r_o      (fcs_r),
		.doe_r_o      (doe_r),
		.select_o     (select)
	);

	// config writes take the data latched in the request register
	z3_autoconfig i_z3_autoconfig (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.cfgin_n_i       (cfgin_n_i),
		.cfg_reg_i       (hit.cfg_reg),
		.cfg_write_stb_i (cfg_write_stb),
		.wdata_i         (mem_req_o.wdata),
		.cfg_nibble_o    (cfg_nibble),
		.base_hi_o       (base_hi),
		.configured_o    (configured),
		.shutup_o        (shutup),
		.cfg_active_o    (cfg_active),
		.cfgout_n_o      (cfgout_n_o)
	);

	z3_cycle_seq i_z3_cycle_seq (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.fcs_r_i         (fcs_r),
		.doe_r_i         (doe_r),
		.select_i        (select),
		.cycle_i         (cycle),
		.hit_i           (hit),
		.wdata_i         (wdata_i),
		.mem_req_ready_i (mem_req_ready_i),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.mem_req_o       (mem_req_o),
		.mem_req_valid_o (mem_req_valid_o),
		.cfg_write_stb_o (cfg_write_stb),
		.slave_n_o       (slave_n_o),
		.dtack_n_o       (dtack_n_o)
	);

	z3_read_data i_z3_read_data (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.cycle_i         (cycle),
		.hit_i           (hit),
		.doe_r_i         (doe_r),
		.slave_n_i       (slave_n_o),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.mem_rsp_rdata_i (mem_rsp_rdata_i),
		.cfg_nibble_i    (cfg_nibble),
		.rdata_o         (rdata_o),
		.data_oe_o       (data_oe_o)
	);

endmodule

/* tb_z3_slave.sv */
// testbench for the Zorro III slave, runs autoconfig, decode and random card cycles against a model
module tb_z3_slave;
	import z3_pkg::*;

	localparam logic [31:0] LFSR_POLY = 32'h80200003;
	localparam logic [5:0] CARD_BASE = 6'h0B;
	localparam int DTACK_LIMIT = 40;
	localparam int SILENT_WINDOW = 12;
	localparam int RANDOM_CYCLES = 200;
	// rom walk, silent probes, base write and probe, random cycles, shut-up phase
	localparam int BUS_CYCLES = 21 + 4 + 2 + RANDOM_CYCLES + 3;
	localparam int TIMEOUT_CYCLES = 64 * BUS_CYCLES + 200;

	logic clk;
	logic rst_n;
	logic fcs_n;
	logic doe;
	logic read;
	logic [BE_W-1:0] ds_n;
	logic [1:0] fc;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic cfgin_n;
	logic req_ready = 1'b0;
	logic rsp_valid = 1'b0;
	logic [DATA_W-1:0] rsp_rdata = '0;
	logic slave_n;
	logic dtack_n;
	logic cfgout_n;
	logic [DATA_W-1:0] rdata;
	logic data_oe;
	mem_req_t mem_req;
	logic req_valid;

	// memory model state
	logic [DATA_W-1:0] mem_model [logic [23:0]];
	mem_req_t exp_req;
	int req_issued = 0;
	int req_seen = 0;
	logic rsp_pending = 1'b0;
	int rsp_delay = 0;
	logic [23:0] rsp_addr = '0;
	logic write_active = 1'b0;
	int cycle_count = 0;
	// separate streams for stimulus and memory, same seed
	logic [31:0] stim_lfsr = 32'h7a30;
	logic [31:0] mem_lfsr = 32'h7a30;

	z3_slave i_z3_slave (
		.clk             (clk),
		.rst_n_i         (rst_n),
		.fcs_n_i         (fcs_n),
		.doe_i           (doe),
		.read_i          (read),
		.ds_n_i          (ds_n),
		.fc_i            (fc),
		.addr_i          (addr),
		.wdata_i         (wdata),
		.cfgin_n_i       (cfgin_n),
		.mem_req_ready_i (req_ready),
		.mem_rsp_valid_i (rsp_valid),
		.mem_rsp_rdata_i (rsp_rdata),
		.slave_n_o       (slave_n),
		.dtack_n_o       (dtack_n),
		.cfgout_n_o      (cfgout_n),
		.rdata_o         (rdata),
		.data_oe_o       (data_oe),
		.mem_req_o       (mem_req),
		.mem_req_valid_o (req_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// galois step, shifts right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
	endfunction

	function automatic logic [31:0] stim_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_next(stim_lfsr);
		end
		return v;
	endfunction

	function automatic logic [31:0] mem_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], mem_lfsr[0]};
			mem_lfsr = lfsr_next(mem_lfsr);
		end
		return v;
	endfunction

	function automatic logic [DATA_W-1:0] read_word(input logic [23:0] wa);
		if (mem_model.exists(wa))
			return mem_model[wa];
		// untouched words, pattern over the full word address
		return {~wa[7:0], wa};
	endfunction

	function automatic void store_word(input mem_req_t req);
		logic [DATA_W-1:0] mask;
		mask = {{8{req.be[3]}}, {8{req.be[2]}}, {8{req.be[1]}}, {8{req.be[0]}}};
		mem_model[req.word_addr] = (read_word(req.word_addr) & ~mask) | (req.wdata & mask);
	endfunction

	// identity nibble on D31..D28, ones below
	function automatic logic [DATA_W-1:0] cfg_word(input logic [6:0] idx);
		logic [3:0] nib;
		if (idx > 7'd15)
			nib = 4'hF;
		else if (idx < 7'd2)
			nib = CFG_ROM[idx[3:0]];
		else
			nib = ~CFG_ROM[idx[3:0]];
		return {nib, 28'hFFF_FFFF};
	endfunction

	function automatic logic [ADDR_W-1:0] cfg_addr(input logic [6:0] idx);
		return {16'hFF00, 7'd0, idx};
	endfunction

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_req(input mem_req_t got, input mem_req_t want, input string what);
		if (got !== want)
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, what, got, want));
	endtask

	task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] want,
		input string what);
		if (got !== want)
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
				$time, what, got, want));
	endtask

	task automatic check_bit(input logic got, input logic want, input string what);
		if (got !== want)
			stop_with_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
				$time, what, got, want));
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		check_bit(slave_n, 1'b1, "slave_n_o in reset");
		check_bit(dtack_n, 1'b1, "dtack_n_o in reset");
		check_bit(cfgout_n, 1'b1, "cfgout_n_o in reset");
		check_bit(req_valid, 1'b0, "mem_req_valid_o in reset");
		check_bit(data_oe, 1'b0, "data_oe_o in reset");
		rst_n = 1'b1;
	endtask

	// address phase, then DOE, strobes late on writes
	task automatic start_cycle(input logic [ADDR_W-1:0] cyc_addr, input logic [1:0] cyc_fc,
		input logic cyc_read, input logic [3:0] cyc_ds_n, input logic [DATA_W-1:0] cyc_wdata);
		@(negedge clk);
		addr = cyc_addr;
		fc = cyc_fc;
		read = cyc_read;
		wdata = cyc_wdata;
		ds_n = '1;
		doe = 1'b0;
		fcs_n = 1'b0;
		@(negedge clk);
		doe = 1'b1;
		if (cyc_read) begin
			ds_n = cyc_ds_n;
		end else begin
			repeat (4) @(negedge clk);
			ds_n = cyc_ds_n;
		end
	endtask

	task automatic end_cycle();
		@(negedge clk);
		fcs_n = 1'b1;
		doe = 1'b0;
		ds_n = '1;
		repeat (2) @(negedge clk);
		check_bit(slave_n, 1'b1, "slave_n_o after cycle end");
		check_bit(dtack_n, 1'b1, "dtack_n_o after cycle end");
		@(negedge clk);
	endtask

	task automatic wait_dtack(input string what);
		int waited;
		waited = 0;
		while (dtack_n !== 1'b0) begin
			@(negedge clk);
			waited++;
			if (waited > DTACK_LIMIT)
				stop_with_error($sformatf("no dtack within %0d cycles on %s", DTACK_LIMIT, what));
		end
	endtask

	task automatic acked_cycle(input logic [ADDR_W-1:0] cyc_addr, input logic [1:0] cyc_fc,
		input logic cyc_read, input logic [3:0] cyc_ds_n, input logic [DATA_W-1:0] cyc_wdata,
		input logic [DATA_W-1:0] expect_word, input string what);
		write_active = ~cyc_read;
		start_cycle(cyc_addr, cyc_fc, cyc_read, cyc_ds_n, cyc_wdata);
		wait_dtack(what);
		check_bit(slave_n, 1'b0, {"slave_n_o at dtack on ", what});
		if (cyc_read) begin
			check_word(rdata, expect_word, what);
			check_bit(data_oe, 1'b1, {"data_oe_o at dtack on ", what});
		end
		end_cycle();
		write_active = 1'b0;
	endtask

	task automatic silent_cycle(input logic [ADDR_W-1:0] cyc_addr, input logic [1:0] cyc_fc,
		input string what);
		start_cycle(cyc_addr, cyc_fc, 1'b1, 4'h0, '0);
		repeat (SILENT_WINDOW) begin
			@(negedge clk);
			check_bit(slave_n, 1'b1, {"slave_n_o on ", what});
			check_bit(dtack_n, 1'b1, {"dtack_n_o on ", what});
			check_bit(req_valid, 1'b0, {"mem_req_valid_o on ", what});
		end
		end_cycle();
	endtask

	// expected request from the bus view of the cycle
	task automatic card_cycle(input logic cyc_read, input logic [23:0] word,
		input logic [3:0] cyc_ds_n, input logic [DATA_W-1:0] cyc_wdata, input logic [1:0] cyc_fc);
		exp_req.op = cyc_read ? MEM_READ : MEM_WRITE;
		exp_req.word_addr = word;
		exp_req.be = ~cyc_ds_n;
		exp_req.wdata = cyc_read ? '0 : cyc_wdata;
		req_issued++;
		acked_cycle({CARD_BASE, word}, cyc_fc, cyc_read, cyc_ds_n, cyc_wdata, read_word(word),
			cyc_read ? "card read" : "card write");
		if (req_seen != req_issued)
			stop_with_error("card cycle acknowledged without an accepted memory request");
	endtask

	// memory side, plus data_oe watch during writes
	always @(negedge clk) begin
		if (write_active)
			check_bit(data_oe, 1'b0, "data_oe_o during a write cycle");
		rsp_valid = 1'b0;
		if (rsp_pending) begin
			if (rsp_delay == 0) begin
				rsp_valid = 1'b1;
				rsp_rdata = read_word(rsp_addr);
				rsp_pending = 1'b0;
			end else begin
				rsp_delay--;
			end
		end
		// ready about three times in four
		req_ready = (mem_bits(2) != 0);
		// valid now and ready set, so taken on the next rising edge
		if (req_ready && req_valid === 1'b1) begin
			if (req_seen == req_issued)
				stop_with_error("memory request appeared outside any card cycle");
			check_req(mem_req, exp_req, "accepted memory request");
			req_seen++;
			if (exp_req.op == MEM_WRITE) begin
				store_word(exp_req);
			end else begin
				rsp_pending = 1'b1;
				rsp_delay = int'(mem_bits(2));
				rsp_addr = exp_req.word_addr;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			stop_with_error($sformatf("timeout, run still going after %0d clock cycles",
				TIMEOUT_CYCLES));
	end

	initial begin
		logic [23:0] word;
		logic [3:0] ds;
		logic rd;
		fcs_n = 1'b1;
		doe = 1'b0;
		read = 1'b1;
		ds_n = '1;
		fc = 2'd0;
		addr = '0;
		wdata = '0;
		cfgin_n = 1'b0;
		rst_n = 1'b0;
		apply_reset();

		// identity walk, chain output stays high
		for (int i = 0; i < 21; i++) begin
			acked_cycle(cfg_addr(7'(i)), (i % 2 == 0) ? 2'd1 : 2'd2, 1'b1, 4'h0, '0,
				cfg_word(7'(i)), "config read");
			check_bit(cfgout_n, 1'b1, "cfgout_n_o before configuration");
		end

		// bad space codes, foreign address, card space while unconfigured
		silent_cycle(cfg_addr(7'd0), 2'd0, "space code 0");
		silent_cycle(cfg_addr(7'd0), 2'd3, "space code 3");
		silent_cycle({16'hFE00, 14'h0}, 2'd1, "address outside both spaces");
		// top bits equal the base value held in reset
		silent_cycle({6'h00, 24'h000010}, 2'd1, "card space before configuration");

		// base address write, then config space goes quiet
		acked_cycle(cfg_addr(CFG_BASE_IDX), 2'd1, 1'b0, 4'h0, {CARD_BASE, 26'h0}, '0,
			"base address write");
		check_bit(cfgout_n, 1'b0, "cfgout_n_o after base write");
		silent_cycle(cfg_addr(7'd0), 2'd1, "config read after configuration");

		// random card traffic
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			rd = 1'(stim_bits(1));
			word = {3'(stim_bits(3)), 16'h0, 5'(stim_bits(5))};
			ds = 4'(stim_bits(4));
			if (ds == 4'hF)
				ds = 4'hE;
			card_cycle(rd, word, ds, stim_bits(32), stim_bits(1) != 0 ? 2'd2 : 2'd1);
		end

		// shut-up after a fresh reset, nothing answers afterwards
		apply_reset();
		acked_cycle(cfg_addr(CFG_SHUTUP_IDX), 2'd1, 1'b0, 4'h0, '0, '0, "shut-up write");
		check_bit(cfgout_n, 1'b0, "cfgout_n_o after shut-up");
		silent_cycle(cfg_addr(7'd0), 2'd1, "config read after shut-up");
		silent_cycle({6'h00, 24'h000004}, 2'd1, "card space after shut-up");

		$display("Finished with no errors");
		$finish;
	end

endmodule

/* z3_slave.f */
z3_pkg.sv
z3_bus_decode.sv
z3_autoconfig.sv
z3_cycle_seq.sv
z3_read_data.sv
z3_slave.sv
tb_z3_slave.sv

/* run_sim.sh */
#!/bin/bash
# build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_z3_slave -f z3_slave.f -o sim_z3_slave \
	&& ./obj_dir/sim_z3_slave 2>&1 | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
grep -qx "Finished with no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
